// File: cpuControlTop.f
rtl/cpuPkg.sv
rtl/irqSync.sv
rtl/statusFlags.sv
rtl/instrDecode.sv
rtl/instrSequencer.sv
rtl/cpuControlTop.sv
verif/cpuControl_asserts.sv
verif/cpuControlTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module cpuControlTb -f cpuControlTop.f -o cpuControlSim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/cpuControlSim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Simulator exited with an error status" >> sim.log
cat sim.log
! grep -q "TEST RESULT: FAIL" sim.log && grep -q "TEST RESULT: PASS" sim.log \
	&& echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed"; exit 1; }

// File: verif/cpuControlTb.sv
// Control unit testbench with random instructions, waits and interrupts, flag and branch model
`default_nettype none

module cpuControlTb;

	localparam int NumInstr = 80;
	localparam int TimeoutCycles = 40 * NumInstr + 200;
	localparam int DriveDelay = 10;
	localparam logic [31:0] Seed = 32'd24433;

	logic Clock;
	logic nReset;
	logic [7:0] OpcodeCondIn;
	logic [3:0] Flags;
	logic nIRQ;
	logic nWait;
	logic ALE;
	logic nME;
	logic nOE;
	logic nWE;
	logic MemEn;
	logic ENB;
	logic IrWe;
	logic RegWe;
	cpuPkg::WdSelect WdSel;
	logic PcWe;
	logic PcEn;
	cpuPkg::PcSelect PcSel;
	logic StatusRegWe;
	logic [3:0] StatusReg;
	logic CFlag;

	logic [31:0] rngState;
	logic [7:0] instrMem [NumInstr];
	logic [7:0] curOp;
	cpuPkg::InstrClass curClass;
	logic [3:0] expectFlags;
	logic loadNext;
	logic intEnabledModel;
	logic disiPending;
	int errors;
	int fetched;
	int cycleCount;
	int sinceIrWe;
	int irqHold;
	int entries;
	int loadWrites;
	int storeWrites;
	int sysPcWrites;

	cpuControlTop #(
		.IrqSyncStages(2)
	) dut0 (
		.Clock(Clock),
		.nReset(nReset),
		.OpcodeCondIn(OpcodeCondIn),
		.Flags(Flags),
		.nIRQ(nIRQ),
		.nWait(nWait),
		.ALE(ALE),
		.nME(nME),
		.nOE(nOE),
		.nWE(nWE),
		.MemEn(MemEn),
		.ENB(ENB),
		.IrWe(IrWe),
		.RegWe(RegWe),
		.WdSel(WdSel),
		.PcWe(PcWe),
		.PcEn(PcEn),
		.PcSel(PcSel),
		.StatusRegWe(StatusRegWe),
		.StatusReg(StatusReg),
		.CFlag(CFlag)
	);

	bind cpuControlTop cpuControl_asserts asserts0 (
		.Clock(Clock),
		.nReset(nReset),
		.nWait(nWait),
		.ALE(ALE),
		.nME(nME),
		.nOE(nOE),
		.nWE(nWE),
		.MemEn(MemEn),
		.ENB(ENB),
		.IrWe(IrWe),
		.RegWe(RegWe),
		.WdSel(WdSel),
		.PcWe(PcWe),
		.PcEn(PcEn),
		.PcSel(PcSel),
		.StatusRegWe(StatusRegWe),
		.IntDisable(intDisable)
	);

	initial begin : clockGen
		Clock = 1'b0;
		forever begin
			#50 Clock = ~Clock;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Mostly ALU work, with loads, stores, branches and the interrupt group mixed in
	function automatic logic [7:0] randomInstr();
		logic [31:0] r;
		logic [2:0] cond;
		r = nextRandom();
		cond = r[10:8];
		case (r[2:0])
			3'd0, 3'd1, 3'd2: return {1'b0, r[6:3], cond};
			3'd3: return {cpuPkg::LDW, cond};
			3'd4: return {cpuPkg::STW, cond};
			3'd5: return {cpuPkg::BRANCH, (cond > 3'd4) ? cond - 3'd4 : cond};
			default: begin
				case (r[9:8])
					2'd0: return {cpuPkg::INTERRUPT, cpuPkg::RETI};
					2'd3: return {cpuPkg::INTERRUPT, cpuPkg::DISI};
					default: return {cpuPkg::INTERRUPT, cpuPkg::ENAI};
				endcase
			end
		endcase
	endfunction

	function automatic cpuPkg::InstrClass classify(input logic [7:0] op);
		// Opcodes below LDW are all ALU operations
		if (op[7:3] < cpuPkg::LDW) return cpuPkg::classAlu;
		if (op[7:3] == cpuPkg::LDW) return cpuPkg::classLoad;
		if (op[7:3] == cpuPkg::STW) return cpuPkg::classStore;
		if (op[7:3] == cpuPkg::BRANCH && op[2:0] <= 3'd4) return cpuPkg::classBranch;
		if (op[7:3] == cpuPkg::INTERRUPT && op[2:0] == cpuPkg::RETI) return cpuPkg::classRetI;
		if (op[7:3] == cpuPkg::INTERRUPT && op[2:0] == cpuPkg::ENAI) return cpuPkg::classIntEnable;
		if (op[7:3] == cpuPkg::INTERRUPT && op[2:0] == cpuPkg::DISI) return cpuPkg::classIntDisable;
		return cpuPkg::classNone;
	endfunction

	function automatic logic condMet(input logic [2:0] cond, input logic [3:0] sr);
		case (cond)
			3'd0: return 1'b1;
			3'd1: return !sr[cpuPkg::FlagZ];
			3'd2: return sr[cpuPkg::FlagZ];
			3'd3: return sr[cpuPkg::FlagN] != sr[cpuPkg::FlagV];
			3'd4: return sr[cpuPkg::FlagN] == sr[cpuPkg::FlagV];
			default: return 1'b0;
		endcase
	endfunction

	task automatic reportMismatch(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	task automatic driveInputs();
		logic [31:0] r;
		r = nextRandom();
		// Instruction register loaded on the last edge, so the decoder sees the new byte
		if (loadNext) begin
			curOp = instrMem[fetched];
			curClass = classify(curOp);
			OpcodeCondIn = curOp;
			fetched++;
			loadNext = 1'b0;
		end
		Flags = r[3:0];
		nWait = (r[5:4] != 2'b00);
		if (irqHold > 0) begin
			irqHold--;
		end else if (r[10:6] == 5'd0) begin
			irqHold = 16;
		end
		nIRQ = (irqHold == 0);
	endtask

	task automatic closeInstr();
		assert (storeWrites == ((curClass == cpuPkg::classStore) ? 1 : 0))
			else reportMismatch($sformatf("%0d store write strobes for op %h", storeWrites, curOp));
		if (curClass == cpuPkg::classLoad) begin
			assert (loadWrites == 1)
				else reportMismatch($sformatf("load wrote the register %0d times", loadWrites));
		end
		if (curClass == cpuPkg::classRetI) begin
			assert (sysPcWrites == 1)
				else reportMismatch("RetI did not load the PC from SysBus once");
		end
		if (disiPending) begin
			intEnabledModel = 1'b0;
			disiPending = 1'b0;
		end
		loadWrites = 0;
		storeWrites = 0;
		sysPcWrites = 0;
	endtask

	task automatic checkExecute();
		logic taken;
		case (curClass)
			cpuPkg::classAlu: begin
				assert (StatusRegWe && PcWe)
					else reportMismatch("ALU execute without status write and PC step");
				assert (RegWe == (curOp[7:3] != cpuPkg::CMP && curOp[7:3] != cpuPkg::CMPI))
					else reportMismatch($sformatf("RegWe %b for ALU op %h", RegWe, curOp));
				expectFlags = Flags;
			end
			cpuPkg::classBranch: begin
				taken = condMet(curOp[2:0], StatusReg);
				assert (PcWe && PcSel == (taken ? cpuPkg::pcAluOut : cpuPkg::pcPlus1))
					else reportMismatch($sformatf("branch %h with status %h gave PcSel %0d",
						curOp, StatusReg, PcSel));
			end
			cpuPkg::classIntEnable: intEnabledModel = 1'b1;
			cpuPkg::classIntDisable: disiPending = 1'b1;
			default: ;
		endcase
	endtask

	task automatic trackMemory();
		if (curClass == cpuPkg::classLoad && RegWe) begin
			loadWrites++;
			assert (nWait && WdSel == cpuPkg::wdSys)
				else reportMismatch("load register write outside its ready read cycle");
		end
		// The vector load cycle carries its own nWE, kept apart by PcWe
		if (!nWE && !PcWe) begin
			storeWrites++;
		end
		if (PcWe && PcSel == cpuPkg::pcSysBus) begin
			sysPcWrites++;
		end
		if (PcWe && PcSel == cpuPkg::pcInt) begin
			assert (intEnabledModel)
				else reportMismatch("interrupt entry while interrupts were disabled");
			intEnabledModel = 1'b0;
			disiPending = 1'b0;
			entries++;
		end
	endtask

	task automatic checkCycle();
		// Status only changes on the edge after an ALU execute cycle
		assert (StatusReg == expectFlags)
			else reportMismatch($sformatf("StatusReg %h, expected %h", StatusReg, expectFlags));
		assert (CFlag == expectFlags[cpuPkg::FlagC])
			else reportMismatch($sformatf("CFlag %b, expected %b", CFlag,
				expectFlags[cpuPkg::FlagC]));
		if (IrWe) begin
			closeInstr();
			sinceIrWe = 0;
			loadNext = 1'b1;
		end else begin
			sinceIrWe++;
			if (sinceIrWe == 2) begin
				checkExecute();
			end else if (sinceIrWe > 2) begin
				trackMemory();
			end
		end
	endtask

	initial begin : stimulus
		int assertFails;
		logic timedOut;
		nReset = 1'b0;
		OpcodeCondIn = 8'h00;
		Flags = 4'h0;
		nIRQ = 1'b1;
		nWait = 1'b1;
		rngState = Seed;
		curOp = 8'h00;
		curClass = cpuPkg::classNone;
		expectFlags = 4'h0;
		loadNext = 1'b0;
		intEnabledModel = 1'b0;
		disiPending = 1'b0;
		timedOut = 1'b0;
		errors = 0;
		fetched = 0;
		cycleCount = 0;
		sinceIrWe = 100;
		irqHold = 0;
		entries = 0;
		loadWrites = 0;
		storeWrites = 0;
		sysPcWrites = 0;
		instrMem[0] = {cpuPkg::INTERRUPT, cpuPkg::ENAI};
		instrMem[1] = {cpuPkg::ADD, 3'd0};
		for (int i = 2; i < NumInstr; i++) begin
			instrMem[i] = randomInstr();
		end
		repeat (8) @(posedge Clock);
		#DriveDelay;
		nReset = 1'b1;
		// nIRQ low from the start, so an interrupt is taken soon after ENAI
		irqHold = 24;
		nIRQ = 1'b0;
		while (fetched < NumInstr && cycleCount < TimeoutCycles) begin
			@(negedge Clock);
			checkCycle();
			@(posedge Clock);
			cycleCount++;
			#DriveDelay;
			driveInputs();
		end
		if (cycleCount >= TimeoutCycles) begin
			timedOut = 1'b1;
			$display("Timeout after %0d cycles with %0d of %0d instructions fetched",
				cycleCount, fetched, NumInstr);
		end
		if (entries == 0) begin
			errors++;
			$display("No interrupt entry happened during the run");
		end
		assertFails = dut0.asserts0.failCount;
		$display("Done after %0d cycles: %0d check errors, %0d assertion failures, %0d entries",
			cycleCount, errors, assertFails, entries);
		if (errors == 0 && assertFails == 0 && !timedOut) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/cpuControl_asserts.sv
// Concurrent assertions on strobe framing, PC selection and interrupt entry
`default_nettype none

module cpuControl_asserts (
	input wire Clock,
	input wire nReset,
	input wire nWait,
	input wire ALE,
	input wire nME,
	input wire nOE,
	input wire nWE,
	input wire MemEn,
	input wire ENB,
	input wire IrWe,
	input wire RegWe,
	input wire cpuPkg::WdSelect WdSel,
	input wire PcWe,
	input wire PcEn,
	input wire cpuPkg::PcSelect PcSel,
	input wire StatusRegWe,
	input wire IntDisable
);

	int failCount = 0;
	logic inEntry;

	// Interrupt entry runs from its IntDisable cycle up to the vector load
	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			inEntry <= 1'b0;
		end else if (PcWe && PcSel == cpuPkg::pcInt) begin
			inEntry <= 1'b0;
		end else if (IntDisable && !PcWe) begin
			inEntry <= 1'b1;
		end
	end

	resetFetch: assert property (@(posedge Clock) disable iff (!nReset)
		$rose(nReset) |-> ALE)
		else begin
			failCount++;
			$error("first cycle after reset is not a fetch address cycle");
		end

	aleSingle: assert property (@(posedge Clock) disable iff (!nReset)
		ALE |=> !ALE && !nME)
		else begin
			failCount++;
			$error("ALE not a single cycle followed by nME low");
		end

	oeWeExclusive: assert property (@(posedge Clock) disable iff (!nReset)
		nOE || nWE)
		else begin
			failCount++;
			$error("nOE and nWE low together");
		end

	irWeFraming: assert property (@(posedge Clock) disable iff (!nReset)
		IrWe |-> nWait && !nME && !nOE && MemEn && ENB)
		else begin
			failCount++;
			$error("IrWe outside a ready read cycle");
		end

	dataEnable: assert property (@(posedge Clock) disable iff (!nReset)
		(MemEn || ENB) |-> !nME && !nOE)
		else begin
			failCount++;
			$error("data bus enabled outside a memory read");
		end

	writeSingle: assert property (@(posedge Clock) disable iff (!nReset)
		!nWE |=> nWE)
		else begin
			failCount++;
			$error("nWE low for more than one cycle");
		end

	loadWrite: assert property (@(posedge Clock) disable iff (!nReset)
		(RegWe && WdSel == cpuPkg::wdSys) |-> nWait && !nOE)
		else begin
			failCount++;
			$error("memory data written to a register outside a ready read");
		end

	statusWrite: assert property (@(posedge Clock) disable iff (!nReset)
		StatusRegWe |-> PcWe && PcSel == cpuPkg::pcPlus1)
		else begin
			failCount++;
			$error("status write outside an ALU execute cycle");
		end

	branchSelect: assert property (@(posedge Clock) disable iff (!nReset)
		(PcSel == cpuPkg::pcAluOut) |-> PcWe)
		else begin
			failCount++;
			$error("branch target selected without PcWe");
		end

	retiSelect: assert property (@(posedge Clock) disable iff (!nReset)
		(PcWe && PcSel == cpuPkg::pcSysBus) |-> nWait && !nOE)
		else begin
			failCount++;
			$error("return PC taken outside a ready read");
		end

	intEntryStart: assert property (@(posedge Clock) disable iff (!nReset)
		(IntDisable && !PcWe) |=> ALE)
		else begin
			failCount++;
			$error("interrupt entry not followed by an address cycle");
		end

	intVector: assert property (@(posedge Clock) disable iff (!nReset)
		(PcWe && PcSel == cpuPkg::pcInt) |-> !nWE && !nME && !$past(nME) && PcEn && inEntry)
		else begin
			failCount++;
			$error("vector load without the return PC write of an entry");
		end

	intReturnFetch: assert property (@(posedge Clock) disable iff (!nReset)
		(PcWe && PcSel == cpuPkg::pcInt) |=> ALE && PcEn)
		else begin
			failCount++;
			$error("no fetch after interrupt entry");
		end

	noFetchInEntry: assert property (@(posedge Clock) disable iff (!nReset)
		inEntry |-> !IrWe)
		else begin
			failCount++;
			$error("instruction fetched during interrupt entry");
		end

endmodule

`default_nettype wire

// File: rtl/cpuControlTop.sv
// Control unit top level with IRQ synchroniser, status flags, decoder and sequencer
`default_nettype none

module cpuControlTop #(
	parameter int IrqSyncStages = 2
) (
	input wire Clock,
	input wire nReset,
	input wire [7:0] OpcodeCondIn,
	input wire [cpuPkg::StatusWidth-1:0] Flags,
	input wire nIRQ,
	input wire nWait,
	output logic ALE,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output logic MemEn,
	output logic ENB,
	output logic IrWe,
	output logic RegWe,
	output cpuPkg::WdSelect WdSel,
	output logic PcWe,
	output logic PcEn,
	output cpuPkg::PcSelect PcSel,
	output logic StatusRegWe,
	output logic [cpuPkg::StatusWidth-1:0] StatusReg,
	output logic CFlag
);

	cpuPkg::InstrClass instrClass;
	cpuPkg::BranchCode branchCode;
	logic writesReg;
	logic writesFlags;
	logic branchTaken;
	logic intReq;
	logic intEnable;
	logic intDisable;

	irqSync #(
		.IrqSyncStages(IrqSyncStages)
	) irqSync0 (
		.Clock(Clock),
		.nReset(nReset),
		.nIRQ(nIRQ),
		.IntEnable(intEnable),
		.IntDisable(intDisable),
		.IntReq(intReq)
	);

	statusFlags statusFlags0 (
		.Clock(Clock),
		.nReset(nReset),
		.Flags(Flags),
		.StatusWe(StatusRegWe),
		.Branch(branchCode),
		.StatusReg(StatusReg),
		.CFlag(CFlag),
		.BranchTaken(branchTaken)
	);

	instrDecode instrDecode0 (
		.OpcodeCondIn(OpcodeCondIn),
		.Class(instrClass),
		.WritesReg(writesReg),
		.WritesFlags(writesFlags),
		.Branch(branchCode)
	);

	// Status write strobe also goes straight out as StatusRegWe
	instrSequencer instrSequencer0 (
		.Clock(Clock),
		.nReset(nReset),
		.Class(instrClass),
		.WritesReg(writesReg),
		.WritesFlags(writesFlags),
		.BranchTaken(branchTaken),
		.IntReq(intReq),
		.nWait(nWait),
		.ALE(ALE),
		.nME(nME),
		.nOE(nOE),
		.nWE(nWE),
		.MemEn(MemEn),
		.ENB(ENB),
		.IrWe(IrWe),
		.RegWe(RegWe),
		.WdSel(WdSel),
		.PcWe(PcWe),
		.PcEn(PcEn),
		.PcSel(PcSel),
		.StatusWe(StatusRegWe),
		.IntEnable(intEnable),
		.IntDisable(intDisable)
	);

endmodule

`default_nettype wire

// File: rtl/instrSequencer.sv
// State and sub-cycle FSM with memory strobes and datapath selects per sub-cycle
`default_nettype none

module instrSequencer (
	input wire Clock,
	input wire nReset,
	input wire cpuPkg::InstrClass Class,
	input wire WritesReg,
	input wire WritesFlags,
	input wire BranchTaken,
	input wire IntReq,
	input wire nWait,
	output logic ALE,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output logic MemEn,
	output logic ENB,
	output logic IrWe,
	output logic RegWe,
	output cpuPkg::WdSelect WdSel,
	output logic PcWe,
	output logic PcEn,
	output cpuPkg::PcSelect PcSel,
	output logic StatusWe,
	output logic IntEnable,
	output logic IntDisable
);

	cpuPkg::CpuState state;
	cpuPkg::CpuState nextState;
	cpuPkg::SubCycle subCycle;
	cpuPkg::SubCycle nextSubCycle;
	logic multiCycle;
	logic instrDone;

	// Load, store and RetI need a memory cycle after cycle4
	assign multiCycle = (Class == cpuPkg::classLoad) || (Class == cpuPkg::classStore) ||
		(Class == cpuPkg::classRetI);
	assign instrDone = (state == cpuPkg::execute) && ((subCycle == cpuPkg::cycle3) ||
		((subCycle == cpuPkg::cycle4) && !multiCycle));

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			state <= cpuPkg::fetch;
			subCycle <= cpuPkg::cycle0;
		end else begin
			state <= nextState;
			subCycle <= nextSubCycle;
		end
	end

	always_comb begin
		nextState = state;
		nextSubCycle = subCycle;
		case (subCycle)
			cpuPkg::cycle0: nextSubCycle = cpuPkg::cycle1;
			cpuPkg::cycle1: nextSubCycle = cpuPkg::cycle2;
			// Memory cycle frozen while nWait is low
			cpuPkg::cycle2: begin
				if (nWait) begin
					nextSubCycle = cpuPkg::cycle3;
				end
			end
			cpuPkg::cycle3: begin
				if (state == cpuPkg::fetch) begin
					nextState = cpuPkg::execute;
					nextSubCycle = cpuPkg::cycle4;
				end else if (state == cpuPkg::interruptEntry) begin
					nextState = cpuPkg::fetch;
					nextSubCycle = cpuPkg::cycle0;
				end
			end
			cpuPkg::cycle4: nextSubCycle = cpuPkg::cycle0;
			default: begin
				nextState = cpuPkg::fetch;
				nextSubCycle = cpuPkg::cycle0;
			end
		endcase
		// Instruction boundary, interrupt entry takes priority over fetch
		if (instrDone) begin
			if (IntReq) begin
				nextState = cpuPkg::interruptEntry;
				nextSubCycle = cpuPkg::cycle4;
			end else begin
				nextState = cpuPkg::fetch;
				nextSubCycle = cpuPkg::cycle0;
			end
		end
	end

	always_comb begin
		// Idle strobes
		ALE = 1'b0;
		nME = 1'b1;
		nOE = 1'b1;
		nWE = 1'b1;
		MemEn = 1'b0;
		ENB = 1'b0;
		IrWe = 1'b0;
		RegWe = 1'b0;
		WdSel = cpuPkg::wdAlu;
		PcWe = 1'b0;
		PcEn = 1'b0;
		PcSel = cpuPkg::pcPlus1;
		StatusWe = 1'b0;
		IntEnable = 1'b0;
		IntDisable = 1'b0;
		case (state)
			cpuPkg::fetch: begin
				case (subCycle)
					cpuPkg::cycle0: begin
						ALE = 1'b1;
						PcEn = 1'b1;
					end
					cpuPkg::cycle1: begin
						nME = 1'b0;
						nOE = 1'b0;
						PcEn = 1'b1;
					end
					cpuPkg::cycle2: begin
						nME = 1'b0;
						nOE = 1'b0;
						MemEn = 1'b1;
						ENB = 1'b1;
						IrWe = nWait;
					end
					default: ;
				endcase
			end
			cpuPkg::execute: begin
				case (subCycle)
					cpuPkg::cycle4: begin
						// Single cycle instructions step the PC here
						PcWe = !multiCycle;
						case (Class)
							cpuPkg::classAlu: begin
								RegWe = WritesReg;
								StatusWe = WritesFlags;
							end
							cpuPkg::classBranch: begin
								if (BranchTaken) begin
									PcSel = cpuPkg::pcAluOut;
								end
							end
							cpuPkg::classIntEnable: IntEnable = 1'b1;
							cpuPkg::classIntDisable: IntDisable = 1'b1;
							default: ;
						endcase
					end
					cpuPkg::cycle0: ALE = 1'b1;
					cpuPkg::cycle1: begin
						nME = 1'b0;
						nOE = (Class == cpuPkg::classStore);
					end
					cpuPkg::cycle2: begin
						nME = 1'b0;
						PcWe = nWait;
						if (Class != cpuPkg::classStore) begin
							nOE = 1'b0;
							MemEn = 1'b1;
							ENB = 1'b1;
						end
						if (Class == cpuPkg::classLoad) begin
							RegWe = nWait;
							WdSel = cpuPkg::wdSys;
						end
						if (Class == cpuPkg::classRetI) begin
							PcSel = cpuPkg::pcSysBus;
						end
					end
					cpuPkg::cycle3: begin
						// Store write strobe
						if (Class == cpuPkg::classStore) begin
							nME = 1'b0;
							nWE = 1'b0;
						end
					end
					default: ;
				endcase
			end
			cpuPkg::interruptEntry: begin
				case (subCycle)
					cpuPkg::cycle4: IntDisable = 1'b1;
					cpuPkg::cycle0: ALE = 1'b1;
					cpuPkg::cycle1: nME = 1'b0;
					cpuPkg::cycle2: begin
						nME = 1'b0;
						PcEn = 1'b1;
					end
					// Return PC written out, vector loaded
					cpuPkg::cycle3: begin
						nME = 1'b0;
						nWE = 1'b0;
						PcEn = 1'b1;
						PcWe = 1'b1;
						PcSel = cpuPkg::pcInt;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/instrDecode.sv
// Opcode and condition split, instruction class and register and flag write needs
`default_nettype none

module instrDecode (
	input wire [7:0] OpcodeCondIn,
	output cpuPkg::InstrClass Class,
	output logic WritesReg,
	output logic WritesFlags,
	output cpuPkg::BranchCode Branch
);

	cpuPkg::Opcode opcode;
	logic isAlu;

	assign opcode = cpuPkg::Opcode'(OpcodeCondIn[7:3]);
	assign Branch = cpuPkg::BranchCode'(OpcodeCondIn[2:0]);

	// ALU operations, compares only touch the flags
	always_comb begin
		isAlu = 1'b0;
		WritesReg = 1'b0;
		case (opcode)
			cpuPkg::CMP, cpuPkg::CMPI: begin
				isAlu = 1'b1;
			end
			cpuPkg::ADD, cpuPkg::ADC, cpuPkg::SUB, cpuPkg::SUC,
			cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR, cpuPkg::NOT,
			cpuPkg::NAND, cpuPkg::NOR, cpuPkg::LSL, cpuPkg::LSR,
			cpuPkg::ASR, cpuPkg::NEG: begin
				isAlu = 1'b1;
				WritesReg = 1'b1;
			end
			default: begin
				isAlu = 1'b0;
				WritesReg = 1'b0;
			end
		endcase
	end

	assign WritesFlags = isAlu;

	always_comb begin
		Class = cpuPkg::classNone;
		if (isAlu) begin
			Class = cpuPkg::classAlu;
		end else begin
			case (opcode)
				cpuPkg::LDW: Class = cpuPkg::classLoad;
				cpuPkg::STW: Class = cpuPkg::classStore;
				cpuPkg::BRANCH: begin
					if (Branch inside {cpuPkg::BR, cpuPkg::BNE, cpuPkg::BE,
							cpuPkg::BLT, cpuPkg::BGE}) begin
						Class = cpuPkg::classBranch;
					end
				end
				// Interrupt group sorted by its condition field
				cpuPkg::INTERRUPT: begin
					case (Branch)
						cpuPkg::RETI: Class = cpuPkg::classRetI;
						cpuPkg::ENAI: Class = cpuPkg::classIntEnable;
						cpuPkg::DISI: Class = cpuPkg::classIntDisable;
						default:      Class = cpuPkg::classNone;
					endcase
				end
				default: Class = cpuPkg::classNone;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/statusFlags.sv
// Status register with ALU flag load, carry output and branch condition evaluation
`default_nettype none

module statusFlags (
	input wire Clock,
	input wire nReset,
	input wire [cpuPkg::StatusWidth-1:0] Flags,
	input wire StatusWe,
	input wire cpuPkg::BranchCode Branch,
	output logic [cpuPkg::StatusWidth-1:0] StatusReg,
	output logic CFlag,
	output logic BranchTaken
);

	logic signMismatch;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			StatusReg <= '0;
		end else if (StatusWe) begin
			StatusReg <= Flags;
		end
	end

	assign CFlag = StatusReg[cpuPkg::FlagC];

	// Signed less than when N and V disagree
	assign signMismatch = StatusReg[cpuPkg::FlagN] ^ StatusReg[cpuPkg::FlagV];

	always_comb begin
		case (Branch)
			cpuPkg::BR:  BranchTaken = 1'b1;
			cpuPkg::BNE: BranchTaken = !StatusReg[cpuPkg::FlagZ];
			cpuPkg::BE:  BranchTaken = StatusReg[cpuPkg::FlagZ];
			cpuPkg::BLT: BranchTaken = signMismatch;
			cpuPkg::BGE: BranchTaken = !signMismatch;
			// interrupt group codes never branch
			default:     BranchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/irqSync.sv
// nIRQ synchroniser chain and interrupt enable latch producing the interrupt request
`default_nettype none

module irqSync #(
	parameter int IrqSyncStages = 2
) (
	input wire Clock,
	input wire nReset,
	input wire nIRQ,
	input wire IntEnable,
	input wire IntDisable,
	output logic IntReq
);

	logic [IrqSyncStages-1:0] syncChain;
	logic intEnabled;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			syncChain <= '0;
			intEnabled <= 1'b0;
		end else begin
			// Request is active high inside the chain
			syncChain[0] <= ~nIRQ;
			for (int i = 1; i < IrqSyncStages; i++) begin
				syncChain[i] <= syncChain[i-1];
			end
			// disable wins if both arrive together
			if (IntDisable) begin
				intEnabled <= 1'b0;
			end else if (IntEnable) begin
				intEnabled <= 1'b1;
			end
		end
	end

	assign IntReq = syncChain[IrqSyncStages-1] & intEnabled;

endmodule

`default_nettype wire

// File: rtl/cpuPkg.sv
// Control unit enums, opcode and condition encodings, status flag positions
`default_nettype none

package cpuPkg;

	// Major state of the sequencer
	typedef enum logic [1:0] {
		fetch          = 2'd0,
		execute        = 2'd1,
		interruptEntry = 2'd2
	} CpuState;

	// cycle4 is the execute or interrupt entry decision cycle
	typedef enum logic [2:0] {
		cycle0 = 3'd0,
		cycle1 = 3'd1,
		cycle2 = 3'd2,
		cycle3 = 3'd3,
		cycle4 = 3'd4
	} SubCycle;

	// Major opcode, bits 7 to 3 of the instruction byte
	typedef enum logic [4:0] {
		ADD       = 5'h00,
		ADC       = 5'h01,
		SUB       = 5'h02,
		SUC       = 5'h03,
		CMP       = 5'h04,
		CMPI      = 5'h05,
		AND       = 5'h06,
		OR        = 5'h07,
		XOR       = 5'h08,
		NOT       = 5'h09,
		NAND      = 5'h0a,
		NOR       = 5'h0b,
		LSL       = 5'h0c,
		LSR       = 5'h0d,
		ASR       = 5'h0e,
		NEG       = 5'h0f,
		LDW       = 5'h10,
		STW       = 5'h11,
		BRANCH    = 5'h12,
		INTERRUPT = 5'h13
	} Opcode;

	// Condition field, upper codes belong to the INTERRUPT group
	typedef enum logic [2:0] {
		BR   = 3'd0,
		BNE  = 3'd1,
		BE   = 3'd2,
		BLT  = 3'd3,
		BGE  = 3'd4,
		RETI = 3'd5,
		ENAI = 3'd6,
		DISI = 3'd7
	} BranchCode;

	typedef enum logic [2:0] {
		classAlu        = 3'd0,
		classLoad       = 3'd1,
		classStore      = 3'd2,
		classBranch     = 3'd3,
		classRetI       = 3'd4,
		classIntEnable  = 3'd5,
		classIntDisable = 3'd6,
		classNone       = 3'd7
	} InstrClass;

	// Next PC source
	typedef enum logic [1:0] {
		pcPlus1  = 2'd0,
		pcAluOut = 2'd1,
		pcSysBus = 2'd2,
		pcInt    = 2'd3
	} PcSelect;

	typedef enum logic {
		wdAlu = 1'b0,
		wdSys = 1'b1
	} WdSelect;

	// Status register layout
	localparam int FlagZ = 0;
	localparam int FlagC = 1;
	localparam int FlagV = 2;
	localparam int FlagN = 3;
	localparam int StatusWidth = 4;

endpackage

`default_nettype wire
